//--- verilog.f
hdl/depPkg.sv
hdl/dependDecode.sv
hdl/regRename.sv
hdl/dependGen.sv
tb/tbDependGen.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench and check its log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f verilog.f --top-module tbDependGen -o simTb \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simTb > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- tb/tbDependGen.sv
`default_nettype none

module tbDependGen import depPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rstN;
	instrT instruction;
	logic instrValid;
	instrClassT instrClass;
	renDepT renDep;
	renameStateT renameState;

	renameStateT modelState; // expected rename state.
	int seed = 74381;

	dependGen DUT (
		.clk(clk),
		.rstN(rstN),
		.instruction(instruction),
		.instrValid(instrValid),
		.instrClass(instrClass),
		.renDep(renDep),
		.renameState(renameState)
	);

	always #50 clk = ~clk;

	task automatic stopRun();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(string name, logic [67:0] expected, logic [67:0] actual);
		assert (actual === expected) else begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stopRun();
		end
	endtask

	// polls the clock and returns just after it reaches the given level.
	task automatic waitEdge(input logic level);
		logic prev;
		int steps;
		prev = clk;
		steps = 0;
		while (!(prev !== level && clk === level)) begin
			prev = clk;
			#1;
			steps++;
			if (steps > 200) begin
				$display("timeout: the clock stopped toggling");
				stopRun();
			end
		end
	endtask

	function automatic instrT encode(instrClassT cls, regIdxT a, regIdxT b, regIdxT c);
		if (cls[4]) begin
			return {4'hF, cls[3:0], b, c};
		end
		return {cls[3:0], a, b, c};
	endfunction

	// expected dependencies for the classes that the tests use.
	function automatic selfDepT tableEntry(instrClassT cls, instrT instr);
		selfDepT d;
		d = '0;
		case (cls)
		5'h00: d.regWrite[instr[3:0]] = 1'b1;
		5'h01: begin
			d.regRead[instr[3:0]] = 1'b1;
			d.regWrite[instr[3:0]] = 1'b1;
		end
		5'h02: begin
			d.regRead = 16'h0002;
			d.regWrite[instr[3:0]] = 1'b1;
			d.special = 3'b010;
		end
		5'h04: begin
			d.regRead[instr[11:8]] = 1'b1;
			d.regRead[instr[7:4]] = 1'b1;
			d.regWrite[instr[3:0]] = 1'b1;
		end
		5'h0B: begin
			d.regRead = 16'h8000;
			d.regRead[instr[11:8]] = 1'b1;
			d.regRead[instr[7:4]] = 1'b1;
			d.regWrite = 16'h8000;
			d.regWrite[instr[3:0]] = 1'b1;
		end
		5'h0E: begin
			d.regRead[instr[11:8]] = 1'b1;
			d.regRead[instr[7:4]] = 1'b1;
			d.regRead[instr[3:0]] = 1'b1;
			d.special = 3'b001;
		end
		5'h18: begin
			d.regRead = 16'h6000;
			d.regRead[instr[7:4]] = 1'b1;
			d.regRead[instr[3:0]] = 1'b1;
			d.regWrite = 16'h6000;
		end
		5'h1A: begin
			d.regRead = 16'h0003;
			d.regRead[instr[7:4]] = 1'b1;
			d.regRead[instr[3:0]] = 1'b1;
			d.regWrite = 16'h0001;
			d.stackPointer = 1'b1;
			d.special = 3'b101; // jump and memWrite.
		end
		5'h1B: begin
			d.regRead = 16'h0001;
			d.regWrite = 16'h0003;
			d.stackPointer = 1'b1;
			d.special = 3'b011;
		end
		default: d = '0;
		endcase
		return d;
	endfunction

	function automatic renameStateT nextStateModel(selfDepT d, renameStateT st);
		renameStateT nxt;
		nxt = st;
		nxt[1:0] = 2'b00;
		for (int r = 2; r < 16; r++) begin
			if (d.regWrite[r] && !d.regRead[r]) begin
				nxt[r] = !st[r]; // a pure write moves to the other bank.
			end
		end
		return nxt;
	endfunction

	function automatic renDepT renameModel(selfDepT d, renameStateT st);
		renDepT res;
		renameStateT nxt;
		res = '0;
		nxt = nextStateModel(d, st);
		res.stackPointer = d.stackPointer;
		res.special = d.special;
		for (int r = 0; r < 16; r++) begin
			res.regRead[st[r] ? r + 16 : r] = d.regRead[r];
			res.regWrite[nxt[r] ? r + 16 : r] = d.regWrite[r];
		end
		return res;
	endfunction

	task automatic driveOnly(instrT instr, logic valid);
		waitEdge(1'b0);
		instruction = instr;
		instrValid = valid;
		#45; // settle, then check just before the rising edge.
	endtask

	task automatic applyInstr(instrClassT cls, regIdxT a, regIdxT b, regIdxT c, logic valid);
		instrT instr;
		selfDepT expDep;
		instr = encode(cls, a, b, c);
		expDep = tableEntry(cls, instr);
		driveOnly(instr, valid);
		checkValue("instrClass", {63'b0, cls}, {63'b0, instrClass});
		checkValue("renDep", renameModel(expDep, modelState), renDep);
		waitEdge(1'b1);
		if (valid) begin
			modelState = nextStateModel(expDep, modelState);
		end
		#1;
		checkValue("renameState", {52'b0, modelState}, {52'b0, renameState});
	endtask

	function automatic regIdxT randomReg(int rnd);
		return rnd[3:0];
	endfunction

	task automatic resetTest();
		checkValue("renameState", 68'b0, {52'b0, renameState});
		applyInstr(5'h00, randomReg($random(seed)), randomReg($random(seed)), 4'd5, 1'b0);
	endtask

	task automatic classTest();
		int rnd;
		for (int n = 0; n < 15; n++) begin
			rnd = $random(seed);
			driveOnly({n[3:0], rnd[11:0]}, 1'b0);
			checkValue("instrClass", {64'b0, n[3:0]}, {63'b0, instrClass});
		end
		for (int n = 0; n < 16; n++) begin
			rnd = $random(seed);
			driveOnly({4'hF, n[3:0], rnd[7:0]}, 1'b0);
			checkValue("instrClass", {63'b0, 1'b1, n[3:0]}, {63'b0, instrClass});
		end
	endtask

	task automatic tableTest();
		instrClassT classes[6] = '{5'h02, 5'h0B, 5'h0E, 5'h18, 5'h1A, 5'h1B};
		for (int i = 0; i < 6; i++) begin
			applyInstr(classes[i], randomReg($random(seed)), randomReg($random(seed)),
				randomReg($random(seed)), 1'b0);
		end
	endtask

	task automatic writeRenameTest();
		regIdxT r;
		logic prevBit;
		for (int i = 0; i < 8; i++) begin
			r = randomReg($random(seed));
			if (r < 4'd2) begin
				r = r + 4'd2;
			end
			prevBit = modelState[r];
			applyInstr(5'h00, randomReg($random(seed)), randomReg($random(seed)), r, 1'b1);
			checkValue("renameState[r]", {67'b0, !prevBit}, {67'b0, renameState[r]});
			applyInstr(5'h04, r, r, randomReg($random(seed)), 1'b0);
		end
	endtask

	task automatic rmwFixedTest();
		regIdxT r;
		logic prevBit;
		physMaskT expSlot;
		for (int i = 0; i < 4; i++) begin
			r = randomReg($random(seed)) | 4'd2;
			prevBit = modelState[r];
			expSlot = '0;
			expSlot[prevBit ? r + 16 : r] = 1'b1; // one bank for the read and the write.
			applyInstr(5'h01, randomReg($random(seed)), randomReg($random(seed)), r, 1'b1);
			checkValue("renameState[r]", {67'b0, prevBit}, {67'b0, renameState[r]});
			checkValue("renDep.regRead", {36'b0, expSlot}, {36'b0, renDep.regRead});
			checkValue("renDep.regWrite", {36'b0, expSlot}, {36'b0, renDep.regWrite});
		end
		for (int i = 0; i < 2; i++) begin
			applyInstr(5'h00, 4'd0, 4'd0, regIdxT'(i), 1'b1);
			checkValue("renDep.regWrite[17:16]", 68'b0, {66'b0, renDep.regWrite[17:16]});
			checkValue("renameState[1:0]", 68'b0, {66'b0, renameState[1:0]});
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instruction = '0;
		instrValid = 1'b0;
		modelState = '0;
		#0.5; // keep polling off the clock edges.
		repeat (10) waitEdge(1'b1);
		waitEdge(1'b0);
		rstN = 1'b1;
		resetTest();
		classTest();
		tableTest();
		writeRenameTest();
		rmwFixedTest();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/dependGen.sv
`default_nettype none

module dependGen import depPkg::*; (
	input logic clk,
	input logic rstN,
	input instrT instruction,
	input logic instrValid,
	output instrClassT instrClass,
	output renDepT renDep,
	output renameStateT renameState
);

	selfDepT selfDep; // dependencies before renaming.

	dependDecode uDecode (
		.instruction(instruction),
		.instrClass(instrClass),
		.selfDep(selfDep)
	);

	// renaming state advances once per valid instruction.
	regRename uRename (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.selfDep(selfDep),
		.renDep(renDep),
		.renameState(renameState)
	);

endmodule

`default_nettype wire

//--- hdl/regRename.sv
`default_nettype none

module regRename import depPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input selfDepT selfDep,
	output renDepT renDep,
	output renameStateT renameState
);

	renameStateT stateNext;

	always_comb begin
		renDep = '0;
		stateNext = renameState;
		renDep.stackPointer = selfDep.stackPointer;
		renDep.special = selfDep.special;

		// r0 and r1 have no shadow copy.
		for (int r = 0; r < firstRenamedReg; r++) begin
			renDep.regRead[r] = selfDep.regRead[r];
			renDep.regWrite[r] = selfDep.regWrite[r];
			stateNext[r] = 1'b0;
		end

		for (int r = firstRenamedReg; r < archRegCount; r++) begin
			// reads come from the bank that is current now.
			if (renameState[r]) begin
				renDep.regRead[r + archRegCount] = selfDep.regRead[r];
			end else begin
				renDep.regRead[r] = selfDep.regRead[r];
			end

			// a pure write starts a fresh copy in the other bank.
			if (selfDep.regWrite[r] && !selfDep.regRead[r]) begin
				stateNext[r] = !renameState[r];
			end

			if (stateNext[r]) begin
				renDep.regWrite[r + archRegCount] = selfDep.regWrite[r];
			end else begin
				renDep.regWrite[r] = selfDep.regWrite[r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			renameState <= '0; // all primary after reset.
		end else if (instrValid) begin
			renameState <= stateNext;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dependDecode.sv
`default_nettype none

module dependDecode import depPkg::*; (
	input instrT instruction,
	output instrClassT instrClass,
	output selfDepT selfDep
);

	regIdxT opA;
	regIdxT opB;
	regIdxT opC;

	assign opA = instruction[11:8];
	assign opB = instruction[7:4];
	assign opC = instruction[3:0];

	// an all ones top nibble extends into the upper half of the class space.
	assign instrClass = (&instruction[15:12]) ? {1'b1, instruction[11:8]} :
		{1'b0, instruction[15:12]};

	always_comb begin
		selfDep = '0;
		case (instrClass)
		5'h00: begin
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h01: begin
			selfDep.regRead[opC] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h02: begin // load through regOne.
			selfDep.regRead[regOne] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
			selfDep.special.memRead = 1'b1;
		end
		5'h03: begin // store through regOne.
			selfDep.regRead[regOne] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.special.memWrite = 1'b1;
		end
		5'h04, 5'h05, 5'h06, 5'h0A, 5'h0C, 5'h0D: begin
			selfDep.regRead[opA] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h07: begin
			selfDep.regRead[opA] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.regWrite[opB] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h08: begin
			selfDep.regRead[opA] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
			selfDep.special.memRead = 1'b1;
		end
		5'h09: begin
			selfDep.regRead[opA] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.special.memWrite = 1'b1;
		end
		5'h0B: begin // add with carry in and out.
			selfDep.regRead[opA] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[regCarry] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
			selfDep.regWrite[regCarry] = 1'b1;
		end
		5'h0E: begin
			selfDep.regRead[opA] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.special.jump = 1'b1;
		end
		5'h10: begin // push.
			selfDep.regRead[opC] = 1'b1;
			selfDep.stackPointer = 1'b1;
			selfDep.special.memWrite = 1'b1;
		end
		5'h11: begin
			selfDep.regRead[opC] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.stackPointer = 1'b1;
			selfDep.special.memWrite = 1'b1;
		end
		5'h12: begin // pop.
			selfDep.regWrite[opC] = 1'b1;
			selfDep.stackPointer = 1'b1;
			selfDep.special.memRead = 1'b1;
		end
		5'h13: begin
			selfDep.regWrite[opC] = 1'b1;
			selfDep.regWrite[opB] = 1'b1;
			selfDep.stackPointer = 1'b1;
			selfDep.special.memRead = 1'b1;
		end
		5'h14, 5'h15, 5'h16: begin
			selfDep.regRead[opB] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h17: begin
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h18: begin // wide result lands in the aux pair.
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.regRead[regAuxA] = 1'b1;
			selfDep.regRead[regAuxB] = 1'b1;
			selfDep.regWrite[regAuxA] = 1'b1;
			selfDep.regWrite[regAuxB] = 1'b1;
		end
		5'h19: begin
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.regWrite[opB] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
		end
		5'h1A: begin // call.
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[opC] = 1'b1;
			selfDep.regRead[regZero] = 1'b1;
			selfDep.regRead[regOne] = 1'b1;
			selfDep.regWrite[regZero] = 1'b1;
			selfDep.stackPointer = 1'b1;
			selfDep.special.jump = 1'b1;
			selfDep.special.memWrite = 1'b1;
		end
		5'h1B: begin
			// return only writes the stack pointer but the flag covers both.
			selfDep.regRead[regZero] = 1'b1;
			selfDep.regWrite[regZero] = 1'b1;
			selfDep.regWrite[regOne] = 1'b1;
			selfDep.stackPointer = 1'b1;
			selfDep.special.jump = 1'b1;
			selfDep.special.memRead = 1'b1;
		end
		5'h1C: begin
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[regAuxA] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
			selfDep.special.memRead = 1'b1;
		end
		5'h1D: begin
			selfDep.regRead[opC] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.regRead[regAuxA] = 1'b1;
			selfDep.special.memWrite = 1'b1;
		end
		5'h1E: begin
			selfDep.regRead[opC] = 1'b1;
			selfDep.regRead[opB] = 1'b1;
			selfDep.special.jump = 1'b1;
		end
		5'h1F: begin
			selfDep.regRead[opC] = 1'b1;
			selfDep.regWrite[opC] = 1'b1;
			selfDep.stackPointer = 1'b1;
		end
		default: begin
			selfDep = '0; // class 0x0F cannot be encoded.
		end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/depPkg.sv
`default_nettype none

package depPkg;

	localparam int unsigned archRegCount = 16;
	localparam int unsigned physRegCount = 32; // primary bank then shadow bank.
	localparam int unsigned instrWidth = 16;
	localparam int unsigned classWidth = 5;
	localparam int unsigned regIdxWidth = 4;

	typedef logic [instrWidth-1:0] instrT;
	typedef logic [classWidth-1:0] instrClassT;
	typedef logic [regIdxWidth-1:0] regIdxT;
	typedef logic [archRegCount-1:0] regMaskT;
	typedef logic [physRegCount-1:0] physMaskT;
	typedef logic [archRegCount-1:0] renameStateT; // set bit selects the shadow copy.

	// fixed register indexes used by the implicit operands.
	localparam regIdxT regZero = 4'd0;
	localparam regIdxT regOne = 4'd1; // also the implicit address register.
	localparam regIdxT regAuxA = 4'd13;
	localparam regIdxT regAuxB = 4'd14;
	localparam regIdxT regCarry = 4'd15;
	localparam int unsigned firstRenamedReg = 2;

	// jump sits in bit 0 and memWrite in bit 2.
	typedef struct packed {
		logic memWrite;
		logic memRead;
		logic jump;
	} specialT;

	// dependencies of one instruction on architectural registers.
	typedef struct packed {
		regMaskT regRead;
		regMaskT regWrite;
		logic stackPointer;
		specialT special;
	} selfDepT;

	// same set mapped onto the physical register slots.
	typedef struct packed {
		physMaskT regRead;
		physMaskT regWrite;
		logic stackPointer;
		specialT special;
	} renDepT;

endpackage

`default_nettype wire
